// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ula
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/ula_settings.svh
STIM    := verif/ula_stimulus.txt

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output.
run: $(BIN) $(STIM)
	./$(BIN) | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+include
verilog/ula_pkg.sv
verilog/ula_bus_ctrl.sv
verilog/ula_ports.sv
verilog/ula_page_map.sv
verilog/ula_screen_fetch.sv
verilog/ula_core.sv
verif/ula_clkgen.sv
verif/ula_asserts.sv
verif/tb_ula.sv

// ==== include/ula_settings.svh ====
`ifndef ULA_SETTINGS_SVH
`define ULA_SETTINGS_SVH

// ====================
// screen fetch
// ====================

// pixel plus attribute bytes.
`define ULA_SCREEN_BYTES    6912
// clocks between fetch slots.
`define ULA_FETCH_PERIOD    16
// clocks n_vrd is held per fetch.
`define ULA_FETCH_LEN       2

// ====================
// ports and va map
// ====================

`define ULA_PORT_FE         16'h00FE
`define ULA_PORT_7FFD       16'h7FFD
`define ULA_VA_ROM_PREFIX   4'b0000
`define ULA_VA_RAM_PREFIX   2'b11
`define ULA_SCREEN_BANK_LO  3'd5
`define ULA_SCREEN_BANK_HI  3'd7

`endif

// ==== verif/tb_ula.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ula_settings.svh"

module tb_ula;

    localparam int TIMEOUT = 64;

    logic        clk28;
    logic        rst_n;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic        n_mreq;
    logic        n_iorq;
    logic        n_rd;
    logic        n_wr;
    logic        n_m1;
    logic        n_rfsh;
    logic [4:0]  kbd;
    logic        tape_in;
    logic [18:0] va;
    logic [7:0]  vd_out;
    logic        vd_oe;
    logic        n_vrd;
    logic        n_vwr;
    logic [2:0]  border;
    logic        beeper;

    int                 errors;
    int                 checks;
    int                 tests;
    int                 fetches;
    logic               timed_out;
    logic [7:0]         lfsr;
    ula_pkg::mem_sel_t  sel_d;      // slot that va and strobes belong to.
    ula_pkg::ram_bank_t bank_m;
    logic               screen_m;
    logic               lock_m;
    ula_pkg::ram_bank_t last_fetch_bank;
    logic               fetch_prev;

    ula_clkgen i_clkgen (
        .clk28 (clk28),
        .rst_n (rst_n)
    );

    ula_core i_dut (
        .clk28   (clk28),
        .rst_n   (rst_n),
        .a       (a),
        .d_in    (d_in),
        .n_mreq  (n_mreq),
        .n_iorq  (n_iorq),
        .n_rd    (n_rd),
        .n_wr    (n_wr),
        .n_m1    (n_m1),
        .n_rfsh  (n_rfsh),
        .kbd     (kbd),
        .tape_in (tape_in),
        .va      (va),
        .vd_out  (vd_out),
        .vd_oe   (vd_oe),
        .n_vrd   (n_vrd),
        .n_vwr   (n_vwr),
        .border  (border),
        .beeper  (beeper)
    );

    always @(posedge clk28) sel_d <= i_dut.mem_sel;

    // ====================
    // helpers
    // ====================

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic check_va(input string name, input logic [18:0] exp, input logic [18:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %05h got %05h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %02h got %02h", $time, name, exp, act);
        end
    endtask

    task automatic check_bank(input string name, input ula_pkg::ram_bank_t exp,
                              input ula_pkg::ram_bank_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input ula_pkg::mem_sel_t exp,
                             input ula_pkg::mem_sel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // ====================
    // bus operations
    // ====================

    task automatic release_bus();
        logic done;
        @(posedge clk28);
        n_mreq <= 1'b1;
        n_iorq <= 1'b1;
        n_rd   <= 1'b1;
        n_wr   <= 1'b1;
        done = 1'b0;
        repeat (2) @(posedge clk28);
        for (int t = 0; t < TIMEOUT && !done; t++) begin
            @(negedge clk28);
            done = n_vwr && !vd_oe && (sel_d != ula_pkg::MEM_ROM) &&
                   (sel_d != ula_pkg::MEM_RAM);
        end
        if (!done) report_timeout("bus did not return to idle");
    endtask

    task automatic mem_access(input logic wr, input logic [15:0] addr,
                              input logic [7:0] data, input logic [18:0] exp);
        ula_pkg::mem_sel_t exp_sel;
        logic              seen;
        exp_sel = (addr[15:14] == 2'b00) ? ula_pkg::MEM_ROM : ula_pkg::MEM_RAM;
        seen = 1'b0;
        @(posedge clk28);
        a      <= addr;
        d_in   <= data;
        n_mreq <= 1'b0;
        n_rd   <= wr;
        n_wr   <= !wr;
        if (wr && exp_sel == ula_pkg::MEM_ROM) begin
            for (int t = 0; t < TIMEOUT && !seen; t++) begin
                @(negedge clk28);
                check_byte("n_vwr", 8'd1, {7'd0, n_vwr});
                seen = (sel_d == ula_pkg::MEM_ROM);
            end
            if (!seen) report_timeout("rom write slot never appeared");
            else begin
                repeat (4) begin
                    @(negedge clk28);
                    check_byte("n_vwr", 8'd1, {7'd0, n_vwr});
                end
            end
        end else begin
            for (int t = 0; t < TIMEOUT && !seen; t++) begin
                @(negedge clk28);
                // a screen fetch may hold n_vrd first.
                seen = (wr ? !n_vwr : !n_vrd) && (sel_d != ula_pkg::MEM_SCREEN);
            end
            if (!seen) report_timeout("no memory strobe for a cpu cycle");
            else begin
                check_va("va", exp, va);
                check_sel("mem_sel", exp_sel, sel_d);
                if (wr) check_byte("n_vrd", 8'd1, {7'd0, n_vrd});
                else check_byte("n_vwr", 8'd1, {7'd0, n_vwr});
                if (addr[15:14] == 2'b11) check_bank("va bank", bank_m, va[16:14]);
            end
        end
        release_bus();
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data,
                            input logic [7:0] exp);
        @(posedge clk28);
        a      <= addr;
        d_in   <= data;
        n_iorq <= 1'b0;
        n_wr   <= 1'b0;
        repeat (3) @(posedge clk28);   // sample, io_wr, register.
        @(negedge clk28);
        if (!addr[0]) check_byte("border/beeper", exp, {3'd0, beeper, 1'b0, border});
        if (!addr[15] && !addr[1] && !lock_m) begin
            bank_m   = data[2:0];
            screen_m = data[3];
            lock_m   = data[5];
        end
        release_bus();
    endtask

    task automatic io_read(input logic [15:0] addr, input logic [7:0] exp);
        logic seen;
        seen = 1'b0;
        @(posedge clk28);
        a      <= addr;
        n_iorq <= 1'b0;
        n_rd   <= 1'b0;
        if (!addr[0]) begin
            for (int t = 0; t < TIMEOUT && !seen; t++) begin
                @(negedge clk28);
                seen = vd_oe;
            end
            if (!seen) report_timeout("vd_oe never rose for a port 0xfe read");
            else begin
                check_byte("vd_out", exp, vd_out);
                @(negedge clk28);
                check_byte("vd_oe", 8'd1, {7'd0, vd_oe});
                check_byte("vd_out", exp, vd_out);
            end
        end else begin
            repeat (4) begin
                @(negedge clk28);
                check_byte("vd_oe", 8'd0, {7'd0, vd_oe});
            end
        end
        release_bus();
    endtask

    task automatic fetch_watch(input int count, input ula_pkg::ram_bank_t exp_bank);
        int start;
        start = fetches;
        for (int t = 0; t < count * `ULA_FETCH_PERIOD * 2 + TIMEOUT &&
                        fetches < start + count; t++) begin
            @(negedge clk28);
        end
        if (fetches < start + count) report_timeout("screen fetches stopped");
        else check_bank("fetch bank", exp_bank, last_fetch_bank);
    endtask

    // ====================
    // fetch monitor
    // ====================

    always @(negedge clk28) begin
        logic fetch_now;
        fetch_now = rst_n && !n_vrd && (sel_d == ula_pkg::MEM_SCREEN);
        if (fetch_now && !fetch_prev) begin
            check_byte("fetch va prefix", {6'd0, `ULA_VA_RAM_PREFIX}, {6'd0, va[18:17]});
            check_bank("fetch va bank",
                       screen_m ? `ULA_SCREEN_BANK_HI : `ULA_SCREEN_BANK_LO, va[16:14]);
            check_va("fetch offset", 19'(fetches % `ULA_SCREEN_BYTES), {6'd0, va[12:0]});
            check_byte("fetch va bit 13", 8'd0, {7'd0, va[13]});
            last_fetch_bank = va[16:14];
            fetches++;
        end
        fetch_prev = fetch_now;
    end

    // ====================
    // main
    // ====================

    initial begin
        int          fd;
        int          rc;
        int          gap;
        int          err_before;
        string       line;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        up;

        a = 16'h0000;
        d_in = 8'h00;
        n_mreq = 1'b1;
        n_iorq = 1'b1;
        n_rd = 1'b1;
        n_wr = 1'b1;
        n_m1 = 1'b1;
        n_rfsh = 1'b1;
        kbd = 5'h15;
        tape_in = 1'b1;
        errors = 0;
        checks = 0;
        tests = 0;
        fetches = 0;
        timed_out = 1'b0;
        fetch_prev = 1'b0;
        lfsr = 8'd76;
        bank_m = 3'd0;
        screen_m = 1'b0;
        lock_m = 1'b0;
        last_fetch_bank = 3'd0;
        up = 1'b0;

        fd = $fopen("verif/ula_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("TEST FAILED");
            $finish;
        end else begin
            for (int t = 0; t < TIMEOUT && !up; t++) begin
                @(posedge clk28);
                up = rst_n;
            end
            if (!up) report_timeout("reset never released");
            while (!timed_out && !$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h", op, addr, data, exp) == 4) begin
                    err_before = errors;
                    case (op)
                        1: mem_access(1'b0, addr[15:0], data[7:0], exp[18:0]);
                        2: mem_access(1'b1, addr[15:0], data[7:0], exp[18:0]);
                        3: io_write(addr[15:0], data[7:0], exp[7:0]);
                        4: io_read(addr[15:0], exp[7:0]);
                        5: fetch_watch(int'(addr), exp[2:0]);
                        default: repeat (int'(addr)) @(posedge clk28);
                    endcase
                    tests++;
                    $display("test %0d op %0d addr %04h %s", tests, op, addr[15:0],
                             (errors == err_before) ? "pass" : "fail");
                    draw_bits(3, gap);
                    repeat (gap) @(posedge clk28);
                end
            end
            $fclose(fd);
            $display("tests %0d checks %0d fetches %0d errors %0d",
                     tests, checks, fetches, errors);
            if (errors == 0 && !timed_out) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/ula_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module ula_asserts (
    input logic       clk28,
    input logic       rst_n,
    input logic [1:0] a_hi,
    input logic       n_mreq,
    input logic       n_vrd,
    input logic       n_vwr,
    input logic       lock,
    input logic [2:0] rampage,
    input logic       screenpage,
    input logic       rompage
);

    // one strobe at a time.
    strobe_excl: assert property (@(posedge clk28) disable iff (!rst_n)
        !(!n_vrd && !n_vwr))
        else $error("n_vrd and n_vwr low together");

    // write strobe trails a cpu ram cycle by two clocks.
    no_rom_write: assert property (@(posedge clk28) disable iff (!rst_n)
        !n_vwr |-> $past(!n_mreq && (a_hi != 2'b00), 2))
        else $error("n_vwr low outside a cpu ram cycle");

    lock_hold: assert property (@(posedge clk28) disable iff (!rst_n)
        $past(lock) |-> ($stable(rampage) && $stable(screenpage) && $stable(rompage)))
        else $error("paging changed while locked");

endmodule

bind ula_core ula_asserts i_asserts (
    .clk28      (clk28),
    .rst_n      (rst_n),
    .a_hi       (a[15:14]),
    .n_mreq     (n_mreq),
    .n_vrd      (n_vrd),
    .n_vwr      (n_vwr),
    .lock       (i_ports.lock),
    .rampage    (rampage),
    .screenpage (screenpage),
    .rompage    (rompage)
);

`default_nettype wire

// ==== verif/ula_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ps

module ula_clkgen (
    output logic clk28,
    output logic rst_n
);

    initial begin
        clk28 = 1'b0;
        forever #5 clk28 = ~clk28;   // 10 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk28);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/ula_stimulus.txt ====
# op addr data expect, all hex. op 0 idle, 1 mem read, 2 mem write, 3 io write, 4 io read,
# 5 fetch watch (addr = fetch count, expect = screen bank). mem ops expect va.
1 0000 00 00000
1 3FFF 00 03FFF
1 4000 00 74000
1 8000 00 68000
1 C000 00 60000
1 C123 00 60123
3 7FFD 13 00
1 0100 00 04100
1 C000 00 6C000
2 4005 AA 74005
2 C010 55 6C010
2 1000 77 00
3 00FE 17 17
3 00FE 0A 02
4 00FE 00 F5
4 00FF 00 00
0 0020 00 00
5 0004 00 5
3 7FFD 2C 00
5 0004 00 7
1 0200 00 00200
1 C001 00 70001
3 7FFD 17 00
1 0200 00 00200
1 C001 00 70001
2 C002 33 70002
5 0003 00 7
1 8000 00 68000

// ==== verilog/ula_bus_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ula_settings.svh"

module ula_bus_ctrl (
    input  logic               clk28,
    input  logic               rst_n,
    input  logic               n_mreq,
    input  logic               n_iorq,
    input  logic               n_rd,
    input  logic               n_wr,
    input  logic               n_m1,
    input  logic               n_rfsh,
    input  logic [1:0]         a_hi,
    input  logic               fetch_due,
    output ula_pkg::mem_sel_t  mem_sel,
    output logic               n_vrd,
    output logic               n_vwr,
    output logic               io_wr,
    output logic               io_rd,
    output logic               fetch_go
);

    localparam int CNT_W = $clog2(`ULA_FETCH_LEN + 1);

    logic             iorq_s;
    logic             rd_s;
    logic             wr_s;
    logic             m1_s;
    logic             io_wr_req;
    logic             io_wr_done;
    logic             cpu_mem;
    logic             cpu_slot;
    logic             bus_idle;
    logic             fetch_busy;
    logic             fetch_grant;
    logic [CNT_W-1:0] fetch_cnt;

    assign cpu_mem     = !n_mreq && n_rfsh;   // refresh never touches va.
    assign bus_idle    = n_mreq && n_iorq;
    assign cpu_slot    = (mem_sel == ula_pkg::MEM_ROM) || (mem_sel == ula_pkg::MEM_RAM);
    assign fetch_busy  = (fetch_cnt != '0);
    // screen reads only after an idle slot.
    assign fetch_grant = fetch_due && bus_idle && !fetch_busy && !fetch_go &&
                         (mem_sel == ula_pkg::MEM_IDLE);
    assign io_wr_req   = iorq_s && wr_s && !m1_s;

    // sampled strobes, active high.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            iorq_s <= 1'b0;
            rd_s   <= 1'b0;
            wr_s   <= 1'b0;
            m1_s   <= 1'b0;
        end else begin
            iorq_s <= !n_iorq;
            rd_s   <= !n_rd;
            wr_s   <= !n_wr;
            m1_s   <= !n_m1;
        end
    end

    // ====================
    // slot classification
    // ====================

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            mem_sel   <= ula_pkg::MEM_IDLE;
            fetch_cnt <= '0;
            fetch_go  <= 1'b0;
        end else begin
            fetch_go <= 1'b0;
            if (fetch_busy) begin
                fetch_cnt <= fetch_cnt - CNT_W'(1);   // cpu waits here.
            end else if (cpu_mem) begin
                mem_sel <= (a_hi == 2'b00) ? ula_pkg::MEM_ROM : ula_pkg::MEM_RAM;
            end else if (fetch_grant) begin
                mem_sel   <= ula_pkg::MEM_SCREEN;
                fetch_cnt <= CNT_W'(`ULA_FETCH_LEN - 1);
                fetch_go  <= 1'b1;
            end else begin
                mem_sel <= ula_pkg::MEM_IDLE;
            end
        end
    end

    // strobes follow the slot by one clock, like va.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            n_vrd <= 1'b1;
            n_vwr <= 1'b1;
        end else begin
            n_vrd <= !((mem_sel == ula_pkg::MEM_SCREEN) || (cpu_slot && rd_s));
            n_vwr <= !((mem_sel == ula_pkg::MEM_RAM) && wr_s);   // rom is read only.
        end
    end

    // ====================
    // i/o cycles
    // ====================

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            io_wr      <= 1'b0;
            io_wr_done <= 1'b0;
            io_rd      <= 1'b0;
        end else begin
            io_wr      <= io_wr_req && !io_wr_done;
            io_wr_done <= io_wr_req;
            io_rd      <= iorq_s && rd_s && !m1_s;   // skip int ack.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ula_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module ula_core (
    input  logic        clk28,
    input  logic        rst_n,
    input  logic [15:0] a,
    input  logic [7:0]  d_in,
    input  logic        n_mreq,
    input  logic        n_iorq,
    input  logic        n_rd,
    input  logic        n_wr,
    input  logic        n_m1,
    input  logic        n_rfsh,
    input  logic [4:0]  kbd,
    input  logic        tape_in,
    output logic [18:0] va,
    output logic [7:0]  vd_out,
    output logic        vd_oe,
    output logic        n_vrd,
    output logic        n_vwr,
    output logic [2:0]  border,
    output logic        beeper
);

    ula_pkg::mem_sel_t  mem_sel;
    ula_pkg::ram_bank_t rampage;
    ula_pkg::rom_page_t rompage;
    logic               screenpage;
    logic               io_wr;
    logic               io_rd;
    logic               fetch_go;
    logic               fetch_due;
    logic [12:0]        scr_addr;

    // ====================
    // control
    // ====================

    ula_bus_ctrl i_bus_ctrl (
        .clk28     (clk28),
        .rst_n     (rst_n),
        .n_mreq    (n_mreq),
        .n_iorq    (n_iorq),
        .n_rd      (n_rd),
        .n_wr      (n_wr),
        .n_m1      (n_m1),
        .n_rfsh    (n_rfsh),
        .a_hi      (a[15:14]),
        .fetch_due (fetch_due),
        .mem_sel   (mem_sel),
        .n_vrd     (n_vrd),
        .n_vwr     (n_vwr),
        .io_wr     (io_wr),
        .io_rd     (io_rd),
        .fetch_go  (fetch_go)
    );

    // ====================
    // datapath
    // ====================

    ula_ports i_ports (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .io_wr      (io_wr),
        .io_rd      (io_rd),
        .a          (a),
        .d_in       (d_in),
        .kbd        (kbd),
        .tape_in    (tape_in),
        .border     (border),
        .beeper     (beeper),
        .rampage    (rampage),
        .screenpage (screenpage),
        .rompage    (rompage),
        .vd_out     (vd_out),
        .vd_oe      (vd_oe)
    );

    ula_page_map i_page_map (
        .clk28      (clk28),
        .rst_n      (rst_n),
        .mem_sel    (mem_sel),
        .a          (a[13:0]),
        .a_hi       (a[15:14]),
        .rampage    (rampage),
        .screenpage (screenpage),
        .rompage    (rompage),
        .scr_addr   (scr_addr),
        .va         (va)
    );

    ula_screen_fetch i_screen_fetch (
        .clk28     (clk28),
        .rst_n     (rst_n),
        .fetch_go  (fetch_go),
        .fetch_due (fetch_due),
        .scr_addr  (scr_addr)
    );

endmodule

`default_nettype wire

// ==== verilog/ula_page_map.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ula_settings.svh"

module ula_page_map (
    input  logic                clk28,
    input  logic                rst_n,
    input  ula_pkg::mem_sel_t   mem_sel,
    input  logic [13:0]         a,
    input  logic [1:0]          a_hi,
    input  ula_pkg::ram_bank_t  rampage,
    input  logic                screenpage,
    input  ula_pkg::rom_page_t  rompage,
    input  logic [12:0]         scr_addr,
    output logic [18:0]         va
);

    localparam ula_pkg::ram_bank_t BANK_4000 = 3'd5;
    localparam ula_pkg::ram_bank_t BANK_8000 = 3'd2;

    ula_pkg::ram_bank_t cpu_bank;
    ula_pkg::ram_bank_t scr_bank;

    // fixed banks below 0xc000.
    always_comb begin
        case (a_hi)
            2'b01:   cpu_bank = BANK_4000;
            2'b10:   cpu_bank = BANK_8000;
            default: cpu_bank = rampage;
        endcase
    end

    assign scr_bank = screenpage ? `ULA_SCREEN_BANK_HI : `ULA_SCREEN_BANK_LO;

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            va <= '0;
        end else begin
            case (mem_sel)
                ula_pkg::MEM_ROM:    va <= {`ULA_VA_ROM_PREFIX, rompage, a};
                ula_pkg::MEM_RAM:    va <= {`ULA_VA_RAM_PREFIX, cpu_bank, a};
                ula_pkg::MEM_SCREEN: va <= {`ULA_VA_RAM_PREFIX, scr_bank, 1'b0, scr_addr};
                default:             va <= va;   // idle holds.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ula_pkg.sv ====
`default_nettype none

package ula_pkg;

    // ====================
    // memory slot
    // ====================

    // what the current memory slot serves.
    typedef enum logic [1:0] {
        MEM_IDLE   = 2'd0,
        MEM_ROM    = 2'd1,
        MEM_RAM    = 2'd2,
        MEM_SCREEN = 2'd3
    } mem_sel_t;

    // ====================
    // paging
    // ====================

    // ram bank number 0 to 7.
    typedef logic [2:0] ram_bank_t;

    // 0 is the 128 editor, 1 is 48 basic.
    typedef logic rom_page_t;

endpackage

`default_nettype wire

// ==== verilog/ula_ports.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ula_settings.svh"

module ula_ports (
    input  logic                clk28,
    input  logic                rst_n,
    input  logic                io_wr,
    input  logic                io_rd,
    input  logic [15:0]         a,
    input  logic [7:0]          d_in,
    input  logic [4:0]          kbd,
    input  logic                tape_in,
    output logic [2:0]          border,
    output logic                beeper,
    output ula_pkg::ram_bank_t  rampage,
    output logic                screenpage,
    output ula_pkg::rom_page_t  rompage,
    output logic [7:0]          vd_out,
    output logic                vd_oe
);

    localparam logic [15:0] PORT_FE   = `ULA_PORT_FE;
    localparam logic [15:0] PORT_7FFD = `ULA_PORT_7FFD;

    logic sel_fe;
    logic sel_7ffd;
    logic lock;

    // partial decode, as on the real machine.
    assign sel_fe   = (a[0] == PORT_FE[0]);
    assign sel_7ffd = (a[15] == PORT_7FFD[15]) && (a[1] == PORT_7FFD[1]);

    // ====================
    // port 0xfe
    // ====================

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            border <= 3'd0;
            beeper <= 1'b0;
        end else if (io_wr && sel_fe) begin
            border <= d_in[2:0];
            beeper <= d_in[4];
        end
    end

    // ====================
    // port 0x7ffd
    // ====================

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            rampage    <= 3'd0;
            screenpage <= 1'b0;
            rompage    <= 1'b0;
            lock       <= 1'b0;
        end else if (io_wr && sel_7ffd && !lock) begin
            rampage    <= d_in[2:0];
            screenpage <= d_in[3];
            rompage    <= d_in[4];
            lock       <= d_in[5];   // sticky until reset.
        end
    end

    // read back. only 0xfe drives the bus.
    assign vd_out = sel_fe ? {1'b1, tape_in, 1'b1, kbd} : 8'hFF;
    assign vd_oe  = io_rd && sel_fe;

endmodule

`default_nettype wire

// ==== verilog/ula_screen_fetch.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "ula_settings.svh"

module ula_screen_fetch (
    input  logic        clk28,
    input  logic        rst_n,
    input  logic        fetch_go,
    output logic        fetch_due,
    output logic [12:0] scr_addr
);

    localparam int PER_W = $clog2(`ULA_FETCH_PERIOD);

    logic [PER_W-1:0] tick_cnt;
    logic             tick;
    logic             go_d;

    assign tick = (tick_cnt == PER_W'(`ULA_FETCH_PERIOD - 1));

    // ====================
    // slot timer
    // ====================

    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + PER_W'(1);
        end
    end

    // one pending fetch absorbs missed slots.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            fetch_due <= 1'b0;
        end else if (tick) begin
            fetch_due <= 1'b1;   // a fresh slot wins over a clear.
        end else if (fetch_go) begin
            fetch_due <= 1'b0;
        end
    end

    // ====================
    // display address
    // ====================

    // step once va has taken the current address.
    always_ff @(posedge clk28 or negedge rst_n) begin
        if (!rst_n) begin
            go_d     <= 1'b0;
            scr_addr <= 13'd0;
        end else begin
            go_d <= fetch_go;
            if (go_d) begin
                if (scr_addr == 13'(`ULA_SCREEN_BYTES - 1))
                    scr_addr <= 13'd0;
                else
                    scr_addr <= scr_addr + 13'd1;
            end
        end
    end

endmodule

`default_nettype wire
